/* Bender.yml */
package:
  name: bitsync_back_end

sources:
  - include_dirs:
      - source
    files:
      - source/bitsyncPkg.sv
      - source/bitsyncRegs.sv
      - source/dcOffsetRemoval.sv
      - source/bitOutputStage.sv
      - source/dacMonitorMux.sv
      - source/bitsyncBackEnd.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/bitsyncBackEndTb.sv

/* all.f */
+incdir+source
source/bitsyncPkg.sv
source/bitsyncRegs.sv
source/dcOffsetRemoval.sv
source/bitOutputStage.sv
source/dacMonitorMux.sv
source/bitsyncBackEnd.sv
verif/bitsyncBackEndTb.sv

/* source/bitOutputStage.sv */
// Rotation is sampled on ch0 symEn only; in sync modes ch1 bits are assumed aligned to ch0 strobes
`timescale 1ns/1ps

module bitOutputStage
    import bitsyncPkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  bsMode_t    mode,
    input  logic [1:0] rotation,
    input  bsChannel_t bsIn [2],
    output logic [1:0] outBit,
    output logic [1:0] vitSym2xEn,
    output logic [1:0] vitSymClk
);

    logic qDelay;
    logic qForCh0;
    logic [1:0] rotated;

    // Returns {ch1, ch0}; qCh0 is the Q bit the ch0 output sees
    function automatic logic [1:0] rotateBits(
        input logic [1:0] rot,
        input logic       iBit,
        input logic       qBit,
        input logic       qCh0
    );
        case (rot)
            2'd0:    return {qBit, iBit};
            2'd1:    return {~iBit, qCh0};
            2'd2:    return {~qBit, ~iBit};
            default: return {iBit, ~qCh0};
        endcase
    endfunction

    //********************************************************************
    // QPSK / OQPSK ambiguity resolution
    //********************************************************************

    // OQPSK uses the Q bit from the previous symbol on the ch0 side
    assign qForCh0 = (mode == OffsetCh) ? qDelay : bsIn[1].bitData;
    assign rotated = rotateBits(rotation, bsIn[0].bitData, bsIn[1].bitData, qForCh0);

    always_ff @(posedge clk) begin
        if (reset) begin
            outBit <= '0;
            qDelay <= 1'b0;
        end else begin
            case (mode)
                DualCh, OffsetCh: begin
                    if (bsIn[0].symEn) begin
                        outBit <= rotated;
                        if (mode == OffsetCh) begin
                            qDelay <= bsIn[1].bitData;
                        end
                    end
                end
                default: begin
                    if (bsIn[0].symEn) begin
                        outBit[0] <= bsIn[0].bitData;
                    end
                    if (bsIn[1].symEn) begin
                        outBit[1] <= bsIn[1].bitData;
                    end
                end
            endcase
        end
    end

    //********************************************************************
    // Viterbi symbol strobes and clocks
    //********************************************************************

    always_comb begin
        case (mode)
            DualCh, OffsetCh: vitSym2xEn = {2{bsIn[0].sym2xEn}};
            default:          vitSym2xEn = {bsIn[1].symEn, bsIn[0].symEn};
        endcase
    end

    // Half-rate clock toggles on every strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            vitSymClk <= '0;
        end else begin
            vitSymClk <= vitSymClk ^ vitSym2xEn;
        end
    end

    rotationKnown: assert property (
        @(posedge clk) disable iff (reset)
        bsIn[0].symEn |-> !$isunknown(rotation)
    );

endmodule

/* source/bitsyncBackEnd.sv */
// Timing-loop results arrive from outside; no back-pressure, every strobe is consumed in its cycle
`timescale 1ns/1ps
`include "bitsyncConsts.svh"

module bitsyncBackEnd
    import bitsyncPkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      clkEn,
    input  busReq_t                   bus,
    input  adcSample_t                rx         [`BS_CH_COUNT],
    input  bsChannel_t                bsIn       [`BS_CH_COUNT],
    input  logic [1:0]                rotation,
    output logic [`BS_BUS_WIDTH-1:0]  dout,
    output bsMode_t                   mode,
    output logic [`BS_DATA_WIDTH-1:0] dcOffset   [`BS_CH_COUNT],
    output logic [1:0]                highImpedance,
    output logic [1:0]                singleEnded,
    output logic [1:0]                outBit,
    output logic [1:0]                vitSym2xEn,
    output logic [1:0]                vitSymClk,
    output dacOut_t                   dac        [`BS_CH_COUNT][`BS_DAC_COUNT]
);

    chanCtrl_t  ctrl [`BS_CH_COUNT];
    dcChannel_t dc   [`BS_CH_COUNT];

    //********************************************************************
    // Control and status
    //********************************************************************

    bitsyncRegs regs (
        .clk   (clk),
        .reset (reset),
        .bus   (bus),
        .lock  ({bsIn[1].lock, bsIn[0].lock}),
        .dout  (dout),
        .mode  (mode),
        .ctrl  (ctrl)
    );

    assign highImpedance = {ctrl[1].highImpedance, ctrl[0].highImpedance};
    assign singleEnded   = {ctrl[1].singleEnded, ctrl[0].singleEnded};

    //********************************************************************
    // Signal path
    //********************************************************************

    dcOffsetRemoval dcLoop (
        .clk   (clk),
        .reset (reset),
        .mode  (mode),
        .ctrl  (ctrl),
        .rx    (rx),
        .bsIn  (bsIn),
        .dc    (dc)
    );

    assign dcOffset[0] = dc[0].offset;
    assign dcOffset[1] = dc[1].offset;

    bitOutputStage bitOut (
        .clk        (clk),
        .reset      (reset),
        .mode       (mode),
        .rotation   (rotation),
        .bsIn       (bsIn),
        .outBit     (outBit),
        .vitSym2xEn (vitSym2xEn),
        .vitSymClk  (vitSymClk)
    );

    // Monitor taps
    dacMonitorMux dacMux (
        .clk   (clk),
        .reset (reset),
        .clkEn (clkEn),
        .ctrl  (ctrl),
        .rx    (rx),
        .bsIn  (bsIn),
        .dc    (dc),
        .dac   (dac)
    );

endmodule

/* source/bitsyncConsts.svh */
// Widths and register byte offsets; every offset assumes a 13-bit byte address on a 32-bit bus
`ifndef BITSYNC_CONSTS_SVH
`define BITSYNC_CONSTS_SVH

//********************************************************************
// Datapath widths
//********************************************************************

// Sample, symbol and offset width
`define BS_DATA_WIDTH       18

// Number of channels
`define BS_CH_COUNT         2

// DC lag accumulator
`define BS_ACCUM_WIDTH      40
`define BS_GAIN_WIDTH       5
`define BS_TEST_WIDTH       8

// Loop input lands at this bit of the accumulator before the gain shift
`define BS_DC_ERR_LSB       16
// Offset is taken from the top of the accumulator
`define BS_DC_OFFSET_LSB    22
// Test override lands here in the offset word
`define BS_DC_TEST_LSB      10

// DAC monitor
`define BS_SEL_WIDTH        4
`define BS_DAC_COUNT        3

//********************************************************************
// Register bus
//********************************************************************

`define BS_BUS_WIDTH        32
`define BS_ADDR_WIDTH       13
`define BS_LANE_COUNT       4

`define BS_REG_MODE         13'h000
`define BS_REG_CH0_CTRL     13'h004
`define BS_REG_CH1_CTRL     13'h008
`define BS_REG_STATUS       13'h00C

`endif

/* source/bitsyncPkg.sv */
// Shared types; chanCtrl_t must stay exactly one bus word wide since it is read back as is
`include "bitsyncConsts.svh"

package bitsyncPkg;

    //********************************************************************
    // Enums
    //********************************************************************

    typedef enum logic [1:0] {
        IndCh    = 2'd0,
        SingleCh = 2'd1,
        DualCh   = 2'd2,
        OffsetCh = 2'd3
    } bsMode_t;

    // Values above DacSym are treated as DacAdc
    typedef enum logic [`BS_SEL_WIDTH-1:0] {
        DacAdc = 4'd0,
        DacDc  = 4'd1,
        DacSym = 4'd2
    } dacSource_t;

    //********************************************************************
    // Structs
    //********************************************************************

    typedef struct packed {
        logic                            cs;
        logic [`BS_LANE_COUNT-1:0]       byteWrite;
        logic [`BS_ADDR_WIDTH-1:0]       addr;
        logic [`BS_BUS_WIDTH-1:0]        din;
    } busReq_t;

    typedef struct packed {
        logic signed [`BS_DATA_WIDTH-1:0] sample;
        logic                             saturated;
    } adcSample_t;

    // One channel of the external timing loop
    typedef struct packed {
        logic                             lock;
        logic                             sym2xEn;
        logic                             symEn;
        logic [`BS_DATA_WIDTH-1:0]        symData;
        logic                             bitData;
        logic signed [`BS_DATA_WIDTH-1:0] dcError;
        logic                             transitionsDetected;
    } bsChannel_t;

    // Field order follows the register bit map, MSB first
    typedef struct packed {
        logic [`BS_TEST_WIDTH-1:0]                    dcTest;
        logic [3:0]                                   reserved;
        logic                                         singleEnded;
        logic                                         highImpedance;
        logic                                         dcEnable;
        logic [`BS_GAIN_WIDTH-1:0]                    dcGain;
        logic [`BS_DAC_COUNT-1:0][`BS_SEL_WIDTH-1:0]  dacSelect;
    } chanCtrl_t;

    typedef struct packed {
        logic [`BS_DATA_WIDTH-1:0] offset;
        logic [`BS_DATA_WIDTH-1:0] loopIn;
        logic                      strobe;
    } dcChannel_t;

    typedef struct packed {
        logic                      clkEn;
        logic [`BS_DATA_WIDTH-1:0] data;
    } dacOut_t;

    // Channels run on their own timing in these modes
    function automatic logic isAsyncMode(input bsMode_t mode);
        return (mode == IndCh) || (mode == SingleCh);
    endfunction

endpackage

/* source/bitsyncRegs.sv */
// Byte-lane writes need cs high in the same cycle; reads are combinational from addr and ignore cs
`timescale 1ns/1ps
`include "bitsyncConsts.svh"

module bitsyncRegs
    import bitsyncPkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  busReq_t                  bus,
    input  logic [1:0]               lock,
    output logic [`BS_BUS_WIDTH-1:0] dout,
    output bsMode_t                  mode,
    output chanCtrl_t                ctrl [`BS_CH_COUNT]
);

    logic                    modeSel;
    logic [`BS_CH_COUNT-1:0] ctrlSel;

    //********************************************************************
    // Address decode
    //********************************************************************

    assign modeSel    = bus.cs && (bus.addr == `BS_REG_MODE);
    assign ctrlSel[0] = bus.cs && (bus.addr == `BS_REG_CH0_CTRL);
    assign ctrlSel[1] = bus.cs && (bus.addr == `BS_REG_CH1_CTRL);

    //********************************************************************
    // Write side
    //********************************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            mode <= IndCh;
            for (int ch = 0; ch < `BS_CH_COUNT; ch++) begin
                ctrl[ch] <= '0;
            end
        end else begin
            // Mode lives in the low bits of lane 0
            if (modeSel && bus.byteWrite[0]) begin
                mode <= bsMode_t'(bus.din[1:0]);
            end
            for (int ch = 0; ch < `BS_CH_COUNT; ch++) begin
                for (int lane = 0; lane < `BS_LANE_COUNT; lane++) begin
                    if (ctrlSel[ch] && bus.byteWrite[lane]) begin
                        ctrl[ch][8*lane +: 8] <= bus.din[8*lane +: 8];
                    end
                end
            end
        end
    end

    //********************************************************************
    // Read mux
    //********************************************************************

    always_comb begin
        case (bus.addr)
            `BS_REG_MODE: begin
                dout = {{(`BS_BUS_WIDTH-2){1'b0}}, mode};
            end
            `BS_REG_CH0_CTRL: begin
                dout = ctrl[0];
            end
            `BS_REG_CH1_CTRL: begin
                dout = ctrl[1];
            end
            // Live lock bits, not latched
            `BS_REG_STATUS: begin
                dout = {{(`BS_BUS_WIDTH-2){1'b0}}, lock};
            end
            default: begin
                dout = '0;
            end
        endcase
    end

    // Unknown strobes would corrupt the registers silently
    busStrobesKnown: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown({bus.cs, bus.byteWrite})
    );

endmodule

/* source/dacMonitorMux.sv */
// Outputs lag their sources by one clock; select codes other than DC and SYM show the ADC sample
`timescale 1ns/1ps
`include "bitsyncConsts.svh"

module dacMonitorMux
    import bitsyncPkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       clkEn,
    input  chanCtrl_t  ctrl [`BS_CH_COUNT],
    input  adcSample_t rx   [`BS_CH_COUNT],
    input  bsChannel_t bsIn [`BS_CH_COUNT],
    input  dcChannel_t dc   [`BS_CH_COUNT],
    output dacOut_t    dac  [`BS_CH_COUNT][`BS_DAC_COUNT]
);

    genvar c;
    genvar d;
    generate
        for (c = 0; c < `BS_CH_COUNT; c++) begin : gChan
            for (d = 0; d < `BS_DAC_COUNT; d++) begin : gDac
                logic                      selStrobe;
                logic [`BS_DATA_WIDTH-1:0] selData;
                logic                      strobeReg;
                logic [`BS_DATA_WIDTH-1:0] dataReg;

                // DAC 1 shows the loop input instead of the offset
                always_comb begin
                    case (dacSource_t'(ctrl[c].dacSelect[d]))
                        DacDc: begin
                            selData   = (d == 1) ? dc[c].loopIn : dc[c].offset;
                            selStrobe = dc[c].strobe;
                        end
                        DacSym: begin
                            selData   = bsIn[c].symData;
                            selStrobe = dc[c].strobe;
                        end
                        default: begin
                            selData   = rx[c].sample;
                            selStrobe = clkEn;
                        end
                    endcase
                end

                always_ff @(posedge clk) begin
                    if (reset) begin
                        strobeReg <= 1'b0;
                    end else begin
                        strobeReg <= selStrobe;
                    end
                end

                always_ff @(posedge clk) begin
                    dataReg <= selData;
                end

                assign dac[c][d] = '{clkEn: strobeReg, data: dataReg};

                // Downstream DAC latches on this strobe
                dacStrobeKnown: assert property (
                    @(posedge clk) disable iff (reset)
                    !$isunknown(strobeReg)
                );
            end
        end
    endgenerate

endmodule

/* source/dcOffsetRemoval.sv */
// Gain is a right shift only, so loop bandwidth moves in factors of two; a nonzero dcTest masks the loop
`timescale 1ns/1ps
`include "bitsyncConsts.svh"

module dcOffsetRemoval
    import bitsyncPkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  bsMode_t    mode,
    input  chanCtrl_t  ctrl [`BS_CH_COUNT],
    input  adcSample_t rx   [`BS_CH_COUNT],
    input  bsChannel_t bsIn [`BS_CH_COUNT],
    output dcChannel_t dc   [`BS_CH_COUNT]
);

    localparam int SignBits = `BS_ACCUM_WIDTH - `BS_DATA_WIDTH - `BS_DC_ERR_LSB;

    genvar n;
    generate
        for (n = 0; n < `BS_CH_COUNT; n++) begin : gChan
            logic                              strobe;
            logic [`BS_DATA_WIDTH-1:0]         loopIn;
            logic signed [`BS_ACCUM_WIDTH-1:0] errorExt;
            logic signed [`BS_ACCUM_WIDTH-1:0] accum;
            logic [`BS_DATA_WIDTH-1:0]         offset;

            //********************************************************************
            // Strobe and loop input selection
            //********************************************************************

            // Ch1 follows ch0 timing unless the channels run independently
            if (n == 0) begin : gStrobe0
                assign strobe = bsIn[0].sym2xEn;
            end else begin : gStrobeN
                assign strobe = isAsyncMode(mode) ? bsIn[n].sym2xEn : bsIn[0].sym2xEn;
            end

            // Fall back to the raw sample without transitions or on clipping
            assign loopIn = (bsIn[n].transitionsDetected && !rx[n].saturated)
                          ? bsIn[n].dcError
                          : rx[n].sample;

            assign errorExt = {{SignBits{loopIn[`BS_DATA_WIDTH-1]}}, loopIn,
                               {`BS_DC_ERR_LSB{1'b0}}};

            //********************************************************************
            // Lag accumulator
            //********************************************************************

            always_ff @(posedge clk) begin
                if (reset || !ctrl[n].dcEnable) begin
                    accum <= '0;
                end else if (strobe) begin
                    accum <= accum + (errorExt >>> ctrl[n].dcGain);
                end
            end

            // Test value overrides the loop for bench alignment
            assign offset = (ctrl[n].dcTest != '0)
                          ? {ctrl[n].dcTest, {`BS_DC_TEST_LSB{1'b0}}}
                          : accum[`BS_ACCUM_WIDTH-1:`BS_DC_OFFSET_LSB];

            assign dc[n] = '{offset: offset, loopIn: loopIn, strobe: strobe};

            // A disabled loop must not leave stale offset behind
            dcClearedWhenDisabled: assert property (
                @(posedge clk) disable iff (reset)
                !ctrl[n].dcEnable |=> (accum == '0)
            );
        end
    endgenerate

endmodule

/* verif/bitsyncBackEndTb.sv */
// Models follow the register shadow, so random writes keep every check valid; DAC data is not reset
`timescale 1ns/1ps
`include "bitsyncConsts.svh"

module bitsyncBackEndTb
    import bitsyncPkg::*;
();

    localparam int TimeoutCycles = 200;

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      clkEn;
    busReq_t                   bus;
    adcSample_t                rx   [2];
    bsChannel_t                bsIn [2];
    logic [1:0]                rotation;
    logic [`BS_BUS_WIDTH-1:0]  dout;
    bsMode_t                   mode;
    logic [`BS_DATA_WIDTH-1:0] dcOffset [2];
    logic [1:0]                highImpedance;
    logic [1:0]                singleEnded;
    logic [1:0]                outBit;
    logic [1:0]                vitSym2xEn;
    logic [1:0]                vitSymClk;
    dacOut_t                   dac [2][3];

    int          errors;
    int          timeouts;
    logic [31:0] randState;
    logic [31:0] r;

    // Reference models
    bsMode_t                   shadowMode;
    logic [31:0]               shadowCtrl [2];
    logic [31:0]               expRead;
    logic signed [39:0]        modelAccum [2];
    logic [`BS_DATA_WIDTH-1:0] expOffset  [2];
    logic [`BS_DATA_WIDTH-1:0] expLoopIn  [2];
    logic [1:0]                expDcStrobe;
    logic [1:0]                expBit;
    logic                      expQ;
    logic [1:0]                expVitEn;
    logic [1:0]                expVitClk;
    dacOut_t                   expDac [2][3];

    always #5 clk = ~clk;

    bitsyncBackEnd UUT (
        .clk           (clk),
        .reset         (reset),
        .clkEn         (clkEn),
        .bus           (bus),
        .rx            (rx),
        .bsIn          (bsIn),
        .rotation      (rotation),
        .dout          (dout),
        .mode          (mode),
        .dcOffset      (dcOffset),
        .highImpedance (highImpedance),
        .singleEnded   (singleEnded),
        .outBit        (outBit),
        .vitSym2xEn    (vitSym2xEn),
        .vitSymClk     (vitSymClk),
        .dac           (dac)
    );

    // xorshift32
    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = randState;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        randState = x;
        return x;
    endfunction

    // Bit map: test [31:24], single 19, hiz 18, enable 17, gain [16:12], selects [11:0]
    function automatic logic [31:0] ctrlWord(input logic [3:0] sel, input logic [4:0] gain,
                                             input logic enable, input logic [7:0] test);
        return {test, 4'b0, 1'b0, 1'b0, enable, gain, sel, sel, sel};
    endfunction

    task automatic reportMismatch(input string name, input logic [39:0] expected,
                                  input logic [39:0] actual);
        errors++;
        $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    //**********************************************************************
    // Register shadow and read model
    //**********************************************************************

    always @(posedge clk) begin
        if (reset) begin
            shadowMode    <= IndCh;
            shadowCtrl[0] <= '0;
            shadowCtrl[1] <= '0;
        end else if (bus.cs) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (bus.byteWrite[lane]) begin
                    case (bus.addr)
                        `BS_REG_MODE: begin
                            if (lane == 0) begin
                                shadowMode <= bsMode_t'(bus.din[1:0]);
                            end
                        end
                        `BS_REG_CH0_CTRL: shadowCtrl[0][8*lane +: 8] <= bus.din[8*lane +: 8];
                        `BS_REG_CH1_CTRL: shadowCtrl[1][8*lane +: 8] <= bus.din[8*lane +: 8];
                        default: ;
                    endcase
                end
            end
        end
    end

    always_comb begin
        case (bus.addr)
            `BS_REG_MODE:     expRead = {30'b0, shadowMode};
            `BS_REG_CH0_CTRL: expRead = shadowCtrl[0];
            `BS_REG_CH1_CTRL: expRead = shadowCtrl[1];
            `BS_REG_STATUS:   expRead = {30'b0, bsIn[1].lock, bsIn[0].lock};
            default:          expRead = '0;
        endcase
    end

    //**********************************************************************
    // DC loop, bit output and DAC models
    //**********************************************************************

    always_comb begin
        for (int n = 0; n < 2; n++) begin
            if (bsIn[n].transitionsDetected && !rx[n].saturated) begin
                expLoopIn[n] = bsIn[n].dcError;
            end else begin
                expLoopIn[n] = rx[n].sample;
            end
            if (shadowCtrl[n][31:24] != 8'd0) begin
                expOffset[n] = {shadowCtrl[n][31:24], 10'b0};
            end else begin
                expOffset[n] = modelAccum[n][39:22];
            end
        end
        expDcStrobe[0] = bsIn[0].sym2xEn;
        if (shadowMode == IndCh || shadowMode == SingleCh) begin
            expDcStrobe[1] = bsIn[1].sym2xEn;
        end else begin
            expDcStrobe[1] = bsIn[0].sym2xEn;
        end
        if (shadowMode == DualCh || shadowMode == OffsetCh) begin
            expVitEn = {2{bsIn[0].sym2xEn}};
        end else begin
            expVitEn = {bsIn[1].symEn, bsIn[0].symEn};
        end
    end

    always @(posedge clk) begin
        logic signed [39:0] step;
        for (int n = 0; n < 2; n++) begin
            if (reset || !shadowCtrl[n][17]) begin
                modelAccum[n] <= '0;
            end else if (expDcStrobe[n]) begin
                step = $signed(expLoopIn[n]);
                step = step <<< 16;
                step = step >>> shadowCtrl[n][16:12];
                modelAccum[n] <= modelAccum[n] + step;
            end
        end
    end

    // Rotation table rows give (ch0, ch1); OQPSK swaps b1 for qDelay on ch0
    always @(posedge clk) begin
        logic b0;
        logic b1;
        logic q;
        b0 = bsIn[0].bitData;
        b1 = bsIn[1].bitData;
        q  = (shadowMode == OffsetCh) ? expQ : b1;
        if (reset) begin
            expBit    <= '0;
            expQ      <= 1'b0;
            expVitClk <= '0;
        end else begin
            expVitClk <= expVitClk ^ expVitEn;
            if (shadowMode == DualCh || shadowMode == OffsetCh) begin
                if (bsIn[0].symEn) begin
                    case (rotation)
                        2'd0: expBit <= {b1, b0};
                        2'd1: expBit <= {~b0, q};
                        2'd2: expBit <= {~b1, ~b0};
                        default: expBit <= {b0, ~q};
                    endcase
                    if (shadowMode == OffsetCh) begin
                        expQ <= b1;
                    end
                end
            end else begin
                if (bsIn[0].symEn) begin
                    expBit[0] <= b0;
                end
                if (bsIn[1].symEn) begin
                    expBit[1] <= b1;
                end
            end
        end
    end

    always @(posedge clk) begin
        logic strobeNext;
        for (int c = 0; c < 2; c++) begin
            for (int d = 0; d < 3; d++) begin
                case (shadowCtrl[c][4*d +: 4])
                    DacDc: begin
                        expDac[c][d].data <= (d == 1) ? expLoopIn[c] : expOffset[c];
                        strobeNext = expDcStrobe[c];
                    end
                    DacSym: begin
                        expDac[c][d].data <= bsIn[c].symData;
                        strobeNext = expDcStrobe[c];
                    end
                    default: begin
                        expDac[c][d].data <= rx[c].sample;
                        strobeNext = clkEn;
                    end
                endcase
                expDac[c][d].clkEn <= reset ? 1'b0 : strobeNext;
            end
        end
    end

    //**********************************************************************
    // Checks
    //**********************************************************************

    readBack: assert property (@(posedge clk) disable iff (reset) dout === expRead)
        else reportMismatch("dout", $sampled(expRead), $sampled(dout));
    modeOut: assert property (@(posedge clk) disable iff (reset) mode === shadowMode)
        else reportMismatch("mode", $sampled(shadowMode), $sampled(mode));
    padCtrl: assert property (@(posedge clk) disable iff (reset)
        {highImpedance, singleEnded} === {shadowCtrl[1][18], shadowCtrl[0][18],
                                          shadowCtrl[1][19], shadowCtrl[0][19]})
        else reportMismatch("highImpedance/singleEnded",
            $sampled({shadowCtrl[1][18], shadowCtrl[0][18], shadowCtrl[1][19], shadowCtrl[0][19]}),
            $sampled({highImpedance, singleEnded}));
    bitsOut: assert property (@(posedge clk) disable iff (reset) outBit === expBit)
        else reportMismatch("outBit", $sampled(expBit), $sampled(outBit));
    vitStrobe: assert property (@(posedge clk) disable iff (reset) vitSym2xEn === expVitEn)
        else reportMismatch("vitSym2xEn", $sampled(expVitEn), $sampled(vitSym2xEn));
    vitClock: assert property (@(posedge clk) disable iff (reset) vitSymClk === expVitClk)
        else reportMismatch("vitSymClk", $sampled(expVitClk), $sampled(vitSymClk));

    for (genvar c = 0; c < 2; c++) begin : gChanCheck
        offsetOut: assert property (@(posedge clk) disable iff (reset)
            dcOffset[c] === expOffset[c])
            else reportMismatch($sformatf("dcOffset[%0d]", c), $sampled(expOffset[c]),
                                $sampled(dcOffset[c]));
        for (genvar d = 0; d < 3; d++) begin : gDacCheck
            dacOut: assert property (@(posedge clk) disable iff (reset)
                dac[c][d] === expDac[c][d])
                else reportMismatch($sformatf("dac[%0d][%0d]", c, d), $sampled(expDac[c][d]),
                                    $sampled(dac[c][d]));
        end
    end

    //**********************************************************************
    // Stimulus
    //**********************************************************************

    // Random bits, strobes and samples; bus idles on a random read address
    task automatic runCycles(input int count);
        logic [31:0] a;
        logic [31:0] s;
        repeat (count) begin
            @(posedge clk);
            for (int n = 0; n < 2; n++) begin
                a = nextRand();
                s = nextRand();
                bsIn[n] <= '{lock: a[0], sym2xEn: a[1], symEn: a[2], symData: a[31:14],
                             bitData: a[3], dcError: s[17:0],
                             transitionsDetected: a[4] | a[5]};
                rx[n] <= '{sample: s[31:14], saturated: a[6] & a[7]};
            end
            a = nextRand();
            clkEn <= a[8];
            bus   <= '{cs: 1'b0, byteWrite: a[3:0], addr: {8'b0, a[12:10], 2'b00},
                       din: nextRand()};
        end
    endtask

    task automatic busWrite(input logic [12:0] addr, input logic [31:0] data,
                            input logic [3:0] lanes);
        runCycles(1);
        bus <= '{cs: 1'b1, byteWrite: lanes, addr: addr, din: data};
    endtask

    task automatic waitForOffset(input int ch);
        int count;
        count = 0;
        do begin
            runCycles(1);
            @(negedge clk);
            count++;
        end while (dcOffset[ch] == '0 && count < TimeoutCycles);
        if (dcOffset[ch] == '0) begin
            timeouts++;
            $display("Timed out waiting for the DC offset of channel %0d to leave zero", ch);
        end
    endtask

    task automatic waitForSymClk(input int ch);
        int count;
        count = 0;
        do begin
            runCycles(1);
            @(negedge clk);
            count++;
        end while (vitSymClk[ch] !== 1'b1 && count < TimeoutCycles);
        if (vitSymClk[ch] !== 1'b1) begin
            timeouts++;
            $display("Timed out waiting for the Viterbi symbol clock of channel %0d", ch);
        end
    endtask

    initial begin
        randState = 32'd21113;
        errors    = 0;
        timeouts  = 0;
        reset     = 1'b1;
        clkEn     = 1'b0;
        rotation  = 2'd0;
        bus       = '0;
        rx[0]     = '0;
        rx[1]     = '0;
        bsIn[0]   = '0;
        bsIn[1]   = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // Random byte-strobed writes, mapped and unmapped
        for (int i = 0; i < 40; i++) begin
            r = nextRand();
            busWrite({8'b0, r[12:10], 2'b00}, nextRand(), r[3:0]);
        end
        runCycles(10);

        // DC loops in an async mode, then a sync mode
        r = nextRand();
        busWrite(`BS_REG_MODE, 32'(IndCh), 4'hF);
        busWrite(`BS_REG_CH0_CTRL, ctrlWord(DacDc, {2'b0, r[2:0]}, 1'b1, 8'h00), 4'hF);
        busWrite(`BS_REG_CH1_CTRL, ctrlWord(DacSym, {2'b0, r[6:4]}, 1'b1, 8'h00), 4'hF);
        waitForOffset(0);
        waitForOffset(1);
        runCycles(40);
        busWrite(`BS_REG_MODE, 32'(DualCh), 4'h1);
        runCycles(40);
        busWrite(`BS_REG_CH0_CTRL, ctrlWord(DacDc, {2'b0, r[2:0]}, 1'b1, 8'hA5), 4'hF);
        runCycles(10);
        busWrite(`BS_REG_CH0_CTRL, ctrlWord(DacDc, 5'd0, 1'b0, 8'h00), 4'hF);
        busWrite(`BS_REG_CH1_CTRL, ctrlWord(DacDc, 5'd0, 1'b0, 8'h00), 4'hF);
        runCycles(10);

        // All rotations in dual and offset channel modes
        busWrite(`BS_REG_MODE, 32'(DualCh), 4'h1);
        waitForSymClk(0);
        for (int m = 0; m < 2; m++) begin
            busWrite(`BS_REG_MODE, (m == 0) ? 32'(DualCh) : 32'(OffsetCh), 4'h1);
            for (int rot = 0; rot < 4; rot++) begin
                rotation <= rot[1:0];
                runCycles(20);
            end
        end
        busWrite(`BS_REG_MODE, 32'(IndCh), 4'h1);
        runCycles(30);
        busWrite(`BS_REG_MODE, 32'(SingleCh), 4'h1);
        waitForSymClk(1);
        runCycles(30);

        // Each DAC source, plus out-of-range codes
        for (int i = 0; i < 5; i++) begin
            r = (i < 4) ? i : 15;
            busWrite(`BS_REG_CH0_CTRL, ctrlWord(r[3:0], 5'd3, 1'b1, 8'h00), 4'hF);
            busWrite(`BS_REG_CH1_CTRL, ctrlWord(r[3:0], 5'd4, 1'b1, 8'h00), 4'hF);
            runCycles(15);
        end
        runCycles(5);

        $display("Assertion errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
